//--- rv_lite.f
rv_lite_pkg.sv
inst_stream_if.sv
fetch_unit.sv
fetch_queue.sv
decode_unit.sv
register_file.sv
pipeline_core.sv
rv_lite_top.sv
rv_lite_properties.sv
rv_lite_tb.sv

//--- rv_lite_tb.sv
module rv_lite_tb import rv_lite_pkg::*; ();

    timeunit 1ns;
    timeprecision 1ps;

    logic             clk;
    logic             reset;
    logic [xlen-1:0]  imem_addr;
    logic [xlen-1:0]  imem_data;
    logic             commit_valid;
    logic [xlen-1:0]  commit_pc;
    logic             commit_wen;
    reg_addr_t        commit_rd;
    logic [xlen-1:0]  commit_data;
    logic             exit;
    logic [xlen-1:0]  gp;

    // instruction memory, 256 words at address zero
    logic [xlen-1:0] imem [0:255];
    int              prog_len;

    // expected commits from the reference model
    logic [xlen-1:0] exp_pc[$];
    logic            exp_wen[$];
    reg_addr_t       exp_rd[$];
    logic [xlen-1:0] exp_data[$];
    logic [xlen-1:0] skip_pcs[$];
    logic [xlen-1:0] ref_gp;

    int errors;
    int checks;
    int cycles;
    int cycle_limit;

    rv_lite_top rv_lite_top_i (
        .clk          (clk),
        .reset        (reset),
        .imem_addr    (imem_addr),
        .imem_data    (imem_data),
        .commit_valid (commit_valid),
        .commit_pc    (commit_pc),
        .commit_wen   (commit_wen),
        .commit_rd    (commit_rd),
        .commit_data  (commit_data),
        .exit         (exit),
        .gp           (gp)
    );

    bind pipeline_core rv_lite_properties rv_lite_properties_i (
        .clk          (clk),
        .reset        (reset),
        .redirect     (redirect),
        .commit_valid (commit_valid),
        .commit_wen   (commit_wen),
        .commit_rd    (commit_rd),
        .exit         (exit)
    );

    // unloaded words never decode to a supported opcode (bits 1:0 are 01)
    function automatic logic [xlen-1:0] fill_word(input logic [xlen-1:0] addr);
        return addr ^ 32'ha5a5_a5a5;
    endfunction

    function automatic logic [xlen-1:0] word_at(input logic [xlen-1:0] addr);
        if (addr[31:10] == '0) begin
            return imem[addr[9:2]];
        end
        return fill_word(addr);
    endfunction

    assign imem_data = word_at(imem_addr);

    // instruction encoders
    function automatic logic [31:0] i_type(input logic [2:0] f3, input reg_addr_t rd,
                                           input reg_addr_t rs1, input logic [11:0] imm);
        return {imm, rs1, f3, rd, 7'b0010011};
    endfunction

    function automatic logic [31:0] r_type(input logic [6:0] f7, input logic [2:0] f3,
                                           input reg_addr_t rd, input reg_addr_t rs1,
                                           input reg_addr_t rs2);
        return {f7, rs2, rs1, f3, rd, 7'b0110011};
    endfunction

    function automatic logic [31:0] u_type(input reg_addr_t rd, input logic [19:0] imm);
        return {imm, rd, 7'b0110111};
    endfunction

    function automatic logic [31:0] b_type(input logic [2:0] f3, input reg_addr_t rs1,
                                           input reg_addr_t rs2, input logic [12:0] off);
        return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], 7'b1100011};
    endfunction

    function automatic logic [31:0] j_type(input reg_addr_t rd, input logic [20:0] off);
        return {off[20], off[10:1], off[11], off[19:12], rd, 7'b1101111};
    endfunction

    task automatic clear_imem();
        for (int i = 0; i < 256; i++) begin
            imem[i] = fill_word(32'(i) << 2);
        end
        prog_len = 0;
        skip_pcs.delete();
    endtask

    task automatic append_inst(input logic [31:0] word);
        imem[prog_len] = word;
        prog_len++;
    endtask

    task automatic expect_word(input string what, input logic [xlen-1:0] exp,
                               input logic [xlen-1:0] got);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Error at %0t: %s expected %h, got %h", $time, what, exp, got);
        end
    endtask

    task automatic match_rd(input string what, input reg_addr_t exp, input reg_addr_t got);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Error at %0t: %s expected x%0d, got x%0d", $time, what, exp, got);
        end
    endtask

    task automatic flag_check(input string what, input logic exp, input logic got);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Error at %0t: %s expected %b, got %b", $time, what, exp, got);
        end
    endtask

    // ISA-level execution of the loaded program, in program order
    task automatic model_program();
        logic [xlen-1:0] regs [0:31];
        logic [xlen-1:0] pc;
        logic [xlen-1:0] next_pc;
        logic [xlen-1:0] w;
        logic [xlen-1:0] imm;
        logic [xlen-1:0] a;
        logic [xlen-1:0] b;
        logic [xlen-1:0] value;
        logic [2:0]      f3;
        logic [6:0]      f7;
        reg_addr_t       rd;
        logic            writes;
        logic            done;
        int              steps;
        for (int i = 0; i < 32; i++) begin
            regs[i] = '0;
        end
        exp_pc.delete();
        exp_wen.delete();
        exp_rd.delete();
        exp_data.delete();
        pc = '0;
        done = 1'b0;
        steps = 0;
        while (!done && steps < 1024) begin
            w = word_at(pc);
            rd = w[11:7];
            f3 = w[14:12];
            f7 = w[31:25];
            a = regs[w[19:15]];
            b = regs[w[24:20]];
            next_pc = pc + 4;
            writes = 1'b0;
            value = '0;
            case (w[6:0])
                7'b0010011: begin
                    imm = {{20{w[31]}}, w[31:20]};
                    writes = 1'b1;
                    case (f3)
                        3'b000: value = a + imm;
                        3'b100: value = a ^ imm;
                        3'b110: value = a | imm;
                        3'b111: value = a & imm;
                        default: writes = 1'b0;
                    endcase
                end
                7'b0110011: begin
                    writes = 1'b1;
                    if (f7 == 7'b0100000 && f3 == 3'b000) begin
                        value = a - b;
                    end else if (f7 == 7'b0000000 && f3 == 3'b000) begin
                        value = a + b;
                    end else if (f7 == 7'b0000000 && f3 == 3'b100) begin
                        value = a ^ b;
                    end else if (f7 == 7'b0000000 && f3 == 3'b110) begin
                        value = a | b;
                    end else if (f7 == 7'b0000000 && f3 == 3'b111) begin
                        value = a & b;
                    end else begin
                        writes = 1'b0;
                    end
                end
                7'b0110111: begin
                    writes = 1'b1;
                    value = {w[31:12], 12'b0};
                end
                7'b1100011: begin
                    imm = {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
                    if ((f3 == 3'b000 && a == b) || (f3 == 3'b001 && a != b)) begin
                        next_pc = pc + imm;
                    end
                end
                7'b1101111: begin
                    imm = {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
                    writes = 1'b1;
                    value = pc + 4;
                    next_pc = pc + imm;
                end
                default: begin
                    done = (w == 32'h0000_0073);
                end
            endcase
            if (rd == '0) begin
                writes = 1'b0;
            end
            exp_pc.push_back(pc);
            exp_wen.push_back(writes);
            exp_rd.push_back(writes ? rd : reg_addr_t'(0));
            exp_data.push_back(writes ? value : '0);
            if (writes) begin
                regs[rd] = value;
            end
            pc = next_pc;
            steps++;
        end
        ref_gp = regs[3];
        if (!done) begin
            errors++;
            $display("reference model never reached an ECALL");
        end
    endtask

    task automatic apply_reset();
        @(negedge clk);
        reset = 1'b1;
        repeat (4) @(negedge clk);
        reset = 1'b0;
    endtask

    task automatic retire_check();
        if (exp_pc.size() == 0) begin
            errors++;
            $display("unexpected commit at pc %h, the program had already ended", commit_pc);
            return;
        end
        foreach (skip_pcs[i]) begin
            if (commit_pc == skip_pcs[i]) begin
                errors++;
                $display("skipped instruction at pc %h committed at %0t", commit_pc, $time);
            end
        end
        expect_word("commit_pc", exp_pc.pop_front(), commit_pc);
        flag_check("commit_wen", exp_wen.pop_front(), commit_wen);
        match_rd("commit_rd", exp_rd.pop_front(), commit_rd);
        expect_word("commit_data", exp_data.pop_front(), commit_data);
    endtask

    // model, reset, compare commits until exit, then watch the halted core
    task automatic run_program(input int hold_cycles);
        cycle_limit += 64 * prog_len;
        model_program();
        apply_reset();
        do begin
            @(negedge clk);
            if (commit_valid) begin
                retire_check();
            end
        end while (!exit);
        repeat (hold_cycles) begin
            @(negedge clk);
            flag_check("exit", 1'b1, exit);
            if (commit_valid) begin
                errors++;
                $display("commit at pc %h after exit was set", commit_pc);
            end
        end
        expect_word("gp", ref_gp, gp);
        if (exp_pc.size() != 0) begin
            errors++;
            $display("%0d expected commits never appeared", exp_pc.size());
        end
    endtask

    task automatic dependent_chain();
        clear_imem();
        append_inst(i_type(3'b000, 1, 0, 5));
        append_inst(i_type(3'b000, 2, 1, 7));
        append_inst(r_type(7'b0000000, 3'b000, 3, 2, 1));
        append_inst(r_type(7'b0100000, 3'b000, 4, 3, 2));
        append_inst(r_type(7'b0000000, 3'b111, 5, 4, 3));
        append_inst(r_type(7'b0000000, 3'b110, 6, 5, 4));
        append_inst(r_type(7'b0000000, 3'b100, 7, 6, 3));
        append_inst(r_type(7'b0000000, 3'b000, 3, 7, 6));
        append_inst(32'h0000_0073);
        run_program(16);
    endtask

    task automatic immediates_and_x0();
        clear_imem();
        append_inst(u_type(1, 20'hfffff));
        append_inst(i_type(3'b000, 2, 0, -1));
        append_inst(i_type(3'b100, 3, 2, 12'hf00));
        append_inst(i_type(3'b110, 4, 1, 12'h7ff));
        append_inst(i_type(3'b111, 5, 2, -16));
        // writes to x0 must retire without a write
        append_inst(i_type(3'b000, 0, 1, 100));
        append_inst(r_type(7'b0000000, 3'b000, 6, 0, 2));
        append_inst(u_type(0, 20'h12345));
        append_inst(r_type(7'b0000000, 3'b110, 7, 0, 0));
        append_inst(32'h0000_0073);
        run_program(16);
    endtask

    task automatic branch_paths();
        clear_imem();
        append_inst(i_type(3'b000, 1, 0, 3));
        append_inst(i_type(3'b000, 2, 0, 3));
        append_inst(i_type(3'b000, 3, 0, 1));
        append_inst(b_type(3'b000, 1, 2, 8));
        skip_pcs.push_back(32'h10);
        append_inst(i_type(3'b000, 3, 3, 100));
        append_inst(b_type(3'b001, 1, 2, 8));
        append_inst(i_type(3'b000, 3, 3, 2));
        append_inst(i_type(3'b000, 4, 0, 9));
        append_inst(b_type(3'b001, 1, 4, 12));
        skip_pcs.push_back(32'h24);
        skip_pcs.push_back(32'h28);
        append_inst(i_type(3'b000, 3, 3, 200));
        append_inst(i_type(3'b000, 3, 3, 400));
        append_inst(b_type(3'b000, 1, 4, 8));
        append_inst(i_type(3'b000, 3, 3, 4));
        // short loop, backward branch taken twice
        append_inst(i_type(3'b000, 5, 0, 3));
        append_inst(i_type(3'b000, 3, 3, 8));
        append_inst(i_type(3'b000, 5, 5, -1));
        append_inst(b_type(3'b001, 5, 0, -8));
        append_inst(32'h0000_0073);
        run_program(16);
    endtask

    task automatic jal_link();
        clear_imem();
        append_inst(i_type(3'b000, 3, 0, 0));
        append_inst(j_type(1, 12));
        skip_pcs.push_back(32'h08);
        skip_pcs.push_back(32'h0c);
        append_inst(i_type(3'b000, 3, 3, 50));
        append_inst(i_type(3'b000, 3, 3, 60));
        append_inst(i_type(3'b000, 3, 3, 1));
        append_inst(j_type(0, 8));
        skip_pcs.push_back(32'h18);
        append_inst(i_type(3'b000, 3, 3, 70));
        append_inst(r_type(7'b0000000, 3'b000, 3, 3, 1));
        append_inst(32'h0000_0073);
        run_program(16);
    endtask

    task automatic exit_and_gp();
        clear_imem();
        append_inst(i_type(3'b000, 3, 0, 12'h123));
        append_inst(u_type(4, 20'habcde));
        append_inst(r_type(7'b0000000, 3'b100, 3, 3, 4));
        append_inst(32'h0000_0073);
        skip_pcs.push_back(32'h10);
        skip_pcs.push_back(32'h14);
        append_inst(i_type(3'b000, 3, 3, 1));
        append_inst(i_type(3'b000, 5, 0, 1));
        run_program(40);
    endtask

    task automatic random_programs();
        int kind;
        reg_addr_t rd;
        reg_addr_t rs1;
        reg_addr_t rs2;
        logic [11:0] imm;
        repeat (4) begin
            clear_imem();
            for (int r = 1; r < 8; r++) begin
                append_inst(i_type(3'b000, r, 0, 12'($urandom)));
            end
            repeat (40) begin
                kind = $urandom % 10;
                rd = $urandom % 8;
                rs1 = $urandom % 8;
                rs2 = $urandom % 8;
                imm = 12'($urandom);
                case (kind)
                    0: append_inst(i_type(3'b000, rd, rs1, imm));
                    1: append_inst(i_type(3'b100, rd, rs1, imm));
                    2: append_inst(i_type(3'b110, rd, rs1, imm));
                    3: append_inst(i_type(3'b111, rd, rs1, imm));
                    4: append_inst(r_type(7'b0000000, 3'b000, rd, rs1, rs2));
                    5: append_inst(r_type(7'b0100000, 3'b000, rd, rs1, rs2));
                    6: append_inst(r_type(7'b0000000, 3'b111, rd, rs1, rs2));
                    7: append_inst(r_type(7'b0000000, 3'b110, rd, rs1, rs2));
                    8: append_inst(r_type(7'b0000000, 3'b100, rd, rs1, rs2));
                    default: append_inst(u_type(rd, 20'($urandom)));
                endcase
            end
            append_inst(32'h0000_0073);
            run_program(16);
        end
    endtask

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // run limit grows with every program that is started
    initial begin
        cycles = 0;
        do begin
            @(posedge clk);
            cycles++;
        end while (cycles < cycle_limit);
        $display("timeout after %0d cycles, the core never finished its programs", cycles);
        $display("Result: FAILED");
        $finish;
    end

    initial begin
        reset = 1'b1;
        errors = 0;
        checks = 0;
        cycle_limit = 0;
        void'($urandom(25173));
        clear_imem();
        dependent_chain();
        immediates_and_x0();
        branch_paths();
        jal_link();
        exit_and_gp();
        random_programs();
        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

//--- rv_lite_properties.sv
module rv_lite_properties import rv_lite_pkg::*; (
    input  logic       clk,
    input  logic       reset,
    input  logic       redirect,
    input  logic       commit_valid,
    input  logic       commit_wen,
    input  reg_addr_t  commit_rd,
    input  logic       exit
);

    timeunit 1ns;
    timeprecision 1ps;

    // a redirect is a single-cycle pulse
    redirect_pulse: assert property (
        @(posedge clk) disable iff (reset)
        redirect |=> !redirect
    ) else $error("redirect stayed high for more than one cycle");

    // nothing retires once the core has stopped
    quiet_after_exit: assert property (
        @(posedge clk) disable iff (reset)
        exit |-> !commit_valid
    ) else $error("instruction committed while exit was set");

    // x0 is never reported as a written register
    rd_not_zero: assert property (
        @(posedge clk) disable iff (reset)
        (commit_valid && commit_wen) |-> (commit_rd != '0)
    ) else $error("commit with write enable names x0");

endmodule

//--- rv_lite_top.sv
module rv_lite_top import rv_lite_pkg::*; #(
    parameter logic [xlen-1:0] reset_pc    = '0,
    parameter int              queue_depth = 4
) (
    input  logic             clk,
    input  logic             reset,
    output logic [xlen-1:0]  imem_addr,
    input  logic [xlen-1:0]  imem_data,
    output logic             commit_valid,
    output logic [xlen-1:0]  commit_pc,
    output logic             commit_wen,
    output reg_addr_t        commit_rd,
    output logic [xlen-1:0]  commit_data,
    output logic             exit,
    output logic [xlen-1:0]  gp
);

    logic            redirect;
    logic [xlen-1:0] redirect_pc;

    // fetch to queue, and queue to pipeline
    inst_stream_if fetch_stream ();
    inst_stream_if queue_stream ();

    fetch_unit #(
        .reset_pc (reset_pc)
    ) fetch_unit_i (
        .clk         (clk),
        .reset       (reset),
        .redirect    (redirect),
        .redirect_pc (redirect_pc),
        .imem_addr   (imem_addr),
        .imem_data   (imem_data),
        .out         (fetch_stream)
    );

    fetch_queue #(
        .queue_depth (queue_depth)
    ) fetch_queue_i (
        .clk      (clk),
        .reset    (reset),
        .redirect (redirect),
        .in       (fetch_stream),
        .out      (queue_stream)
    );

    pipeline_core pipeline_core_i (
        .clk          (clk),
        .reset        (reset),
        .in           (queue_stream),
        .redirect     (redirect),
        .redirect_pc  (redirect_pc),
        .commit_valid (commit_valid),
        .commit_pc    (commit_pc),
        .commit_wen   (commit_wen),
        .commit_rd    (commit_rd),
        .commit_data  (commit_data),
        .exit         (exit),
        .gp           (gp)
    );

endmodule

//--- pipeline_core.sv
module pipeline_core import rv_lite_pkg::*; (
    input  logic             clk,
    input  logic             reset,
    inst_stream_if.sink      in,
    output logic             redirect,
    output logic [xlen-1:0]  redirect_pc,
    output logic             commit_valid,
    output logic [xlen-1:0]  commit_pc,
    output logic             commit_wen,
    output reg_addr_t        commit_rd,
    output logic [xlen-1:0]  commit_data,
    output logic             exit,
    output logic [xlen-1:0]  gp
);

    // ID stage
    logic            id_valid;
    logic [xlen-1:0] id_pc;
    logic [xlen-1:0] id_inst;
    ctrl_t           id_ctrl;
    logic [xlen-1:0] id_rf1;
    logic [xlen-1:0] id_rf2;
    logic [xlen-1:0] id_op1;
    logic [xlen-1:0] id_op2;

    // EX stage
    logic            ex_valid;
    logic [xlen-1:0] ex_pc;
    ctrl_t           ex_ctrl;
    logic [xlen-1:0] ex_op1;
    logic [xlen-1:0] ex_op2;
    logic [xlen-1:0] ex_alu_b;
    logic [xlen-1:0] ex_alu_out;
    logic [xlen-1:0] ex_result;
    logic            ex_taken;

    // WB stage
    logic            wb_valid;
    logic [xlen-1:0] wb_pc;
    ctrl_t           wb_ctrl;
    logic [xlen-1:0] wb_data;

    logic pop;
    // ECALL at commit, everything younger is dropped
    logic halt;

    assign in.ready = !exit;
    assign pop      = in.valid && in.ready;
    assign halt     = wb_valid && wb_ctrl.exit;

    always_ff @(posedge clk) begin
        if (pop) begin
            id_pc   <= in.pc;
            id_inst <= in.inst;
        end
    end

    decode_unit decode_unit_i (
        .inst (id_inst),
        .ctrl (id_ctrl)
    );

    register_file register_file_i (
        .clk    (clk),
        .rs1    (id_ctrl.rs1),
        .rs2    (id_ctrl.rs2),
        .rdata1 (id_rf1),
        .rdata2 (id_rf2),
        .wen    (wb_valid && wb_ctrl.wen),
        .waddr  (wb_ctrl.rd),
        .wdata  (wb_data),
        .gp     (gp)
    );

    // youngest producer wins, wen implies rd is not x0
    always_comb begin
        if (ex_valid && ex_ctrl.wen && ex_ctrl.rd == id_ctrl.rs1) begin
            id_op1 = ex_result;
        end else if (wb_valid && wb_ctrl.wen && wb_ctrl.rd == id_ctrl.rs1) begin
            id_op1 = wb_data;
        end else begin
            id_op1 = id_rf1;
        end
        if (ex_valid && ex_ctrl.wen && ex_ctrl.rd == id_ctrl.rs2) begin
            id_op2 = ex_result;
        end else if (wb_valid && wb_ctrl.wen && wb_ctrl.rd == id_ctrl.rs2) begin
            id_op2 = wb_data;
        end else begin
            id_op2 = id_rf2;
        end
    end

    always_ff @(posedge clk) begin
        ex_pc   <= id_pc;
        ex_ctrl <= id_ctrl;
        ex_op1  <= id_op1;
        ex_op2  <= id_op2;
    end

    assign ex_alu_b = ex_ctrl.use_imm ? ex_ctrl.imm : ex_op2;

    always_comb begin
        case (ex_ctrl.alu_op)
            alu_sub:      ex_alu_out = ex_op1 - ex_alu_b;
            alu_and:      ex_alu_out = ex_op1 & ex_alu_b;
            alu_or:       ex_alu_out = ex_op1 | ex_alu_b;
            alu_xor:      ex_alu_out = ex_op1 ^ ex_alu_b;
            alu_pass_imm: ex_alu_out = ex_ctrl.imm;
            default:      ex_alu_out = ex_op1 + ex_alu_b;
        endcase
    end

    // jal links pc+4, non-writing ops carry zero
    assign ex_result = !ex_ctrl.wen ? '0 :
                       (ex_ctrl.branch == br_jal) ? ex_pc + 32'd4 : ex_alu_out;

    always_comb begin
        case (ex_ctrl.branch)
            br_eq:   ex_taken = (ex_op1 == ex_op2);
            br_ne:   ex_taken = (ex_op1 != ex_op2);
            br_jal:  ex_taken = 1'b1;
            default: ex_taken = 1'b0;
        endcase
    end

    assign redirect    = ex_valid && ex_taken;
    assign redirect_pc = ex_pc + ex_ctrl.imm;

    always_ff @(posedge clk) begin
        wb_pc   <= ex_pc;
        wb_ctrl <= ex_ctrl;
        wb_data <= ex_result;
    end

    // stage valids
    always_ff @(posedge clk) begin
        if (reset || halt) begin
            id_valid <= 1'b0;
            ex_valid <= 1'b0;
            wb_valid <= 1'b0;
        end else begin
            // the word popped during a redirect is already wrong path
            id_valid <= pop && !redirect;
            ex_valid <= id_valid && !redirect;
            wb_valid <= ex_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            exit <= 1'b0;
        end else if (halt) begin
            exit <= 1'b1;
        end
    end

    assign commit_valid = wb_valid;
    assign commit_pc    = wb_pc;
    assign commit_wen   = wb_ctrl.wen;
    assign commit_rd    = wb_ctrl.rd;
    assign commit_data  = wb_data;

endmodule

//--- register_file.sv
module register_file import rv_lite_pkg::*; (
    input  logic             clk,
    input  reg_addr_t        rs1,
    input  reg_addr_t        rs2,
    output logic [xlen-1:0]  rdata1,
    output logic [xlen-1:0]  rdata2,
    input  logic             wen,
    input  reg_addr_t        waddr,
    input  logic [xlen-1:0]  wdata,
    output logic [xlen-1:0]  gp
);

    // x1..x31, x0 has no storage
    logic [xlen-1:0] regs [1:31];

    always_ff @(posedge clk) begin
        if (wen && waddr != '0) begin
            regs[waddr] <= wdata;
        end
    end

    // asynchronous reads
    assign rdata1 = (rs1 == '0) ? '0 : regs[rs1];
    assign rdata2 = (rs2 == '0) ? '0 : regs[rs2];

    assign gp = regs[3];

endmodule

//--- decode_unit.sv
module decode_unit import rv_lite_pkg::*; (
    input  logic [xlen-1:0]  inst,
    output ctrl_t            ctrl
);

    opcode_e         opcode;
    logic [2:0]      funct3;
    logic [6:0]      funct7;
    logic [xlen-1:0] imm_i;
    logic [xlen-1:0] imm_u;
    logic [xlen-1:0] imm_b;
    logic [xlen-1:0] imm_j;

    assign opcode = opcode_e'(inst[6:0]);
    assign funct3 = inst[14:12];
    assign funct7 = inst[31:25];

    // immediate formats, all sign extended from bit 31
    assign imm_i = {{20{inst[31]}}, inst[31:20]};
    assign imm_u = {inst[31:12], 12'b0};
    assign imm_b = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
    assign imm_j = {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};

    always_comb begin
        // unknown encodings fall out as a no-op
        ctrl         = '0;
        ctrl.alu_op  = alu_add;
        ctrl.branch  = br_none;
        ctrl.rs1     = inst[19:15];
        ctrl.rs2     = inst[24:20];
        ctrl.rd      = inst[11:7];
        case (opcode)
            op_imm: begin
                ctrl.use_imm = 1'b1;
                ctrl.imm     = imm_i;
                ctrl.wen     = (funct3 == 3'b000) || (funct3 == 3'b100) ||
                               (funct3 == 3'b110) || (funct3 == 3'b111);
                ctrl.alu_op  = (funct3 == 3'b100) ? alu_xor :
                               (funct3 == 3'b110) ? alu_or  :
                               (funct3 == 3'b111) ? alu_and : alu_add;
            end
            op_reg: begin
                if (funct7 == 7'b0100000 && funct3 == 3'b000) begin
                    ctrl.wen    = 1'b1;
                    ctrl.alu_op = alu_sub;
                end else if (funct7 == 7'b0000000) begin
                    ctrl.wen    = (funct3 == 3'b000) || (funct3 == 3'b100) ||
                                  (funct3 == 3'b110) || (funct3 == 3'b111);
                    ctrl.alu_op = (funct3 == 3'b100) ? alu_xor :
                                  (funct3 == 3'b110) ? alu_or  :
                                  (funct3 == 3'b111) ? alu_and : alu_add;
                end
            end
            op_lui: begin
                ctrl.wen     = 1'b1;
                ctrl.use_imm = 1'b1;
                ctrl.alu_op  = alu_pass_imm;
                ctrl.imm     = imm_u;
            end
            op_branch: begin
                ctrl.imm    = imm_b;
                ctrl.branch = (funct3 == 3'b000) ? br_eq :
                              (funct3 == 3'b001) ? br_ne : br_none;
            end
            op_jal: begin
                // link value pc+4 is formed in EX
                ctrl.wen    = 1'b1;
                ctrl.imm    = imm_j;
                ctrl.branch = br_jal;
            end
            op_system: begin
                ctrl.exit = (inst == inst_ecall);
            end
            default: begin
                ctrl.wen = 1'b0;
            end
        endcase
        // x0 is never written, and a non-writing op reports rd zero
        if (ctrl.rd == '0) begin
            ctrl.wen = 1'b0;
        end
        if (!ctrl.wen) begin
            ctrl.rd = '0;
        end
    end

endmodule

//--- fetch_queue.sv
module fetch_queue import rv_lite_pkg::*; #(
    parameter int queue_depth = 4
) (
    input  logic           clk,
    input  logic           reset,
    input  logic           redirect,
    inst_stream_if.sink    in,
    inst_stream_if.source  out
);

    localparam int ptr_w = $clog2(queue_depth);
    localparam logic [ptr_w:0] full_count = (ptr_w + 1)'(queue_depth);

    // entry storage
    logic [xlen-1:0] pc_mem   [queue_depth];
    logic [xlen-1:0] inst_mem [queue_depth];

    logic [ptr_w-1:0] wr_ptr;
    logic [ptr_w-1:0] rd_ptr;
    logic [ptr_w:0]   count;

    logic push;
    logic pop;

    // full queue stalls the fetch unit
    assign in.ready  = (count != full_count);
    assign out.valid = (count != '0);
    assign out.pc    = pc_mem[rd_ptr];
    assign out.inst  = inst_mem[rd_ptr];

    assign push = in.valid && in.ready;
    assign pop  = out.valid && out.ready;

    always_ff @(posedge clk) begin
        if (push) begin
            pc_mem[wr_ptr]   <= in.pc;
            inst_mem[wr_ptr] <= in.inst;
        end
    end

    always_ff @(posedge clk) begin
        if (reset || redirect) begin
            // wrong path work is dropped here
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({push, pop})
                2'b10: begin
                    count <= count + 1'b1;
                end
                2'b01: begin
                    count <= count - 1'b1;
                end
                default: begin
                    count <= count;
                end
            endcase
        end
    end

endmodule

//--- fetch_unit.sv
module fetch_unit import rv_lite_pkg::*; #(
    parameter logic [xlen-1:0] reset_pc = '0
) (
    input  logic             clk,
    input  logic             reset,
    input  logic             redirect,
    input  logic [xlen-1:0]  redirect_pc,
    output logic [xlen-1:0]  imem_addr,
    input  logic [xlen-1:0]  imem_data,
    inst_stream_if.source    out
);

    logic [xlen-1:0] pc;
    // low only in the cycles spent in reset
    logic            running;

    assign imem_addr = pc;

    // the memory answers in the same cycle, so the word is stable while pc is held
    assign out.pc   = pc;
    assign out.inst = imem_data;

    // the word at pc is stale when a redirect arrives
    assign out.valid = running && !redirect;

    always_ff @(posedge clk) begin
        if (reset) begin
            running <= 1'b0;
        end else begin
            running <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            pc <= reset_pc;
        end else if (redirect) begin
            pc <= redirect_pc;
        end else if (out.valid && out.ready) begin
            // sequential fetch, no prediction
            pc <= pc + 32'd4;
        end
    end

endmodule

//--- inst_stream_if.sv
interface inst_stream_if import rv_lite_pkg::*; ();

    // one fetched instruction with its address
    logic             valid;
    logic             ready;
    logic [xlen-1:0]  pc;
    logic [xlen-1:0]  inst;

    modport source (
        output valid,
        output pc,
        output inst,
        input  ready
    );

    modport sink (
        input  valid,
        input  pc,
        input  inst,
        output ready
    );

endinterface

//--- rv_lite_pkg.sv
package rv_lite_pkg;

    // data and address width
    localparam int xlen = 32;

    // encoding of the only supported system instruction
    localparam logic [xlen-1:0] inst_ecall = 32'h0000_0073;

    typedef logic [4:0] reg_addr_t;

    // major opcodes of the supported subset
    typedef enum logic [6:0] {
        op_imm    = 7'b0010011,
        op_reg    = 7'b0110011,
        op_lui    = 7'b0110111,
        op_branch = 7'b1100011,
        op_jal    = 7'b1101111,
        op_system = 7'b1110011
    } opcode_e;

    typedef enum logic [2:0] {
        alu_add      = 3'd0,
        alu_sub      = 3'd1,
        alu_and      = 3'd2,
        alu_or       = 3'd3,
        alu_xor      = 3'd4,
        alu_pass_imm = 3'd5
    } alu_op_e;

    // control transfer kind, resolved in EX
    typedef enum logic [1:0] {
        br_none = 2'd0,
        br_eq   = 2'd1,
        br_ne   = 2'd2,
        br_jal  = 2'd3
    } branch_e;

    // decoded control, travels from ID down to WB
    typedef struct packed {
        reg_addr_t        rs1;
        reg_addr_t        rs2;
        reg_addr_t        rd;
        logic             wen;
        alu_op_e          alu_op;
        logic             use_imm;
        branch_e          branch;
        logic             exit;
        logic [xlen-1:0]  imm;
    } ctrl_t;

endpackage
